// File: hw/sram_fifo_pkg.sv
// Fixed geometry of 18-bit words in a 1024-word NoBL SRAM with an 8-entry return buffer
package sram_fifo_pkg;

   // Word width matches the SRAM data bus
   localparam int DATA_W = 18;

   // SRAM address width and the FIFO capacity it gives
   localparam int ADDR_W = 10;
   localparam int FIFO_WORDS = 1 << ADDR_W;

   // Stored and readable counts must reach FIFO_WORDS itself
   localparam int CNT_W = ADDR_W + 1;

   // Return buffer geometry
   localparam int RBUF_PTR_W = 3;
   localparam int RBUF_DEPTH = 1 << RBUF_PTR_W;

   // Outstanding reads go up to RBUF_DEPTH inclusive
   localparam int CREDIT_W = RBUF_PTR_W + 1;

   // Cycles from a push until its word may be read back.
   // Keeps a read behind its own late write in the SRAM pipeline
   localparam int WR_VISIBLE_DELAY = 3;

endpackage

// File: hw/nobl_if.sv
// Read data returns exactly 4 cycles after req_en; no back-pressure, no byte lanes or bursts
`timescale 1ns/1ps

module nobl_if
   import sram_fifo_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              req_en,
   input  logic              req_write,
   input  logic [ADDR_W-1:0] req_addr,
   input  logic [DATA_W-1:0] req_data,
   input  logic [DATA_W-1:0] ram_dq_rd,
   output logic [DATA_W-1:0] rd_data,
   output logic              rd_valid,
   output logic [ADDR_W-1:0] ram_a,
   output logic              ram_we_n,
   output logic              ram_ce1_n,
   output logic [DATA_W-1:0] ram_dq_wr,
   output logic              ram_dq_drive_n
);

   // Stage 1 state drives the address and control pins directly
   logic              en_p1;
   logic              wr_p1;
   logic [ADDR_W-1:0] addr_p1;
   logic [DATA_W-1:0] data_p1;

   // Stages 2 and 3 carry the late write data
   logic              en_p2;
   logic              wr_p2;
   logic [DATA_W-1:0] data_p2;

   logic              en_p3;
   logic              wr_p3;
   logic [DATA_W-1:0] data_p3;

   // Stage 1
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         en_p1 <= 1'b0;
         wr_p1 <= 1'b0;
      end
      else
      begin
         en_p1 <= req_en;
         wr_p1 <= req_en & req_write;
      end
   end

   always_ff @(posedge clk)
   begin
      if (req_en)
         addr_p1 <= req_addr;
      if (req_en & req_write)
         data_p1 <= req_data;
   end

   assign ram_a     = addr_p1;
   assign ram_we_n  = ~wr_p1;
   assign ram_ce1_n = ~en_p1;

   // Stage 2
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         en_p2 <= 1'b0;
         wr_p2 <= 1'b0;
      end
      else
      begin
         en_p2 <= en_p1;
         wr_p2 <= wr_p1;
      end
   end

   always_ff @(posedge clk)
   begin
      data_p2 <= data_p1;
   end

   // Stage 3 puts the data out two cycles after its address
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         en_p3          <= 1'b0;
         wr_p3          <= 1'b0;
         ram_dq_drive_n <= 1'b1;
      end
      else
      begin
         en_p3          <= en_p2;
         wr_p3          <= wr_p2;
         // Active low driver enable for an enabled write
         ram_dq_drive_n <= ~(en_p2 & wr_p2);
      end
   end

   always_ff @(posedge clk)
   begin
      data_p3 <= data_p2;
   end

   assign ram_dq_wr = data_p3;

   // Stage 4 registers the bus every cycle and marks only reads valid
   always_ff @(posedge clk)
   begin
      if (rst)
         rd_valid <= 1'b0;
      else
         rd_valid <= en_p3 & ~wr_p3;
   end

   always_ff @(posedge clk)
   begin
      rd_data <= ram_dq_rd;
   end

endmodule

// File: hw/sram_fifo_ctrl.sv
// full counts words still in the SRAM only; pushes while full are dropped, a push beats a read
`timescale 1ns/1ps

module sram_fifo_ctrl
   import sram_fifo_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              push,
   input  logic [DATA_W-1:0] push_data,
   input  logic              pop,
   output logic              full,
   output logic              req_en,
   output logic              req_write,
   output logic [ADDR_W-1:0] req_addr,
   output logic [DATA_W-1:0] req_data
);

   logic [ADDR_W-1:0]           wr_ptr;
   logic [ADDR_W-1:0]           rd_ptr;
   logic [CNT_W-1:0]            stored_cnt;
   logic [CNT_W-1:0]            readable_cnt;
   logic [CREDIT_W-1:0]         credit_cnt;
   logic [WR_VISIBLE_DELAY-2:0] vis_sr;
   logic                        push_acc;
   logic                        rd_issue;
   logic                        word_ready;
   logic                        credit_free;
   logic                        vis_now;

   assign full = (stored_cnt == CNT_W'(FIFO_WORDS));

   assign push_acc    = push & ~full;
   assign word_ready  = (readable_cnt != '0);
   assign credit_free = (credit_cnt < CREDIT_W'(RBUF_DEPTH));

   // Reads only fill otherwise idle request slots
   assign rd_issue = ~push_acc & word_ready & credit_free;

   // Request to the SRAM interface, one per cycle at most
   assign req_en    = push_acc | rd_issue;
   assign req_write = push_acc;
   assign req_addr  = push_acc ? wr_ptr : rd_ptr;
   assign req_data  = push_data;

   // Pointers wrap naturally at FIFO_WORDS
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push_acc)
            wr_ptr <= wr_ptr + ADDR_W'(1);
         if (rd_issue)
            rd_ptr <= rd_ptr + ADDR_W'(1);
      end
   end

   // Words not yet read out of the SRAM.
   // Push and read never share a cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         stored_cnt <= '0;
      else if (push_acc)
         stored_cnt <= stored_cnt + CNT_W'(1);
      else if (rd_issue)
         stored_cnt <= stored_cnt - CNT_W'(1);
   end

   // Push delay line; the readable counter adds the last stage,
   // so a word is readable WR_VISIBLE_DELAY cycles after its push
   always_ff @(posedge clk)
   begin
      if (rst)
         vis_sr <= '0;
      else
         vis_sr <= {vis_sr[WR_VISIBLE_DELAY-3:0], push_acc};
   end

   assign vis_now = vis_sr[WR_VISIBLE_DELAY-2];

   always_ff @(posedge clk)
   begin
      if (rst)
         readable_cnt <= '0;
      else
      begin
         case ({vis_now, rd_issue})
            2'b10:   readable_cnt <= readable_cnt + CNT_W'(1);
            2'b01:   readable_cnt <= readable_cnt - CNT_W'(1);
            default: readable_cnt <= readable_cnt;
         endcase
      end
   end

   // Reads issued but not yet handed to the consumer
   always_ff @(posedge clk)
   begin
      if (rst)
         credit_cnt <= '0;
      else
      begin
         case ({rd_issue, pop})
            2'b10:   credit_cnt <= credit_cnt + CREDIT_W'(1);
            2'b01:   credit_cnt <= credit_cnt - CREDIT_W'(1);
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

endmodule

// File: hw/sram_read_buf.sv
// Never overflows only because the controller caps outstanding reads at RBUF_DEPTH
`timescale 1ns/1ps

module sram_read_buf
   import sram_fifo_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              rd_valid,
   input  logic [DATA_W-1:0] rd_data,
   input  logic              out_hold,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data,
   output logic              pop
);

   logic [DATA_W-1:0]     mem [RBUF_DEPTH];
   logic [RBUF_PTR_W-1:0] wr_ptr;
   logic [RBUF_PTR_W-1:0] rd_ptr;
   logic [RBUF_PTR_W:0]   count;
   logic                  deliver;

   // One word leaves per cycle while not held
   assign deliver = (count != '0) & ~out_hold;

   // Credit release to the controller
   assign pop = deliver;

   always_ff @(posedge clk)
   begin
      if (rd_valid)
         mem[wr_ptr] <= rd_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (rd_valid)
            wr_ptr <= wr_ptr + RBUF_PTR_W'(1);
         if (deliver)
            rd_ptr <= rd_ptr + RBUF_PTR_W'(1);
         case ({rd_valid, deliver})
            2'b10:   count <= count + (RBUF_PTR_W+1)'(1);
            2'b01:   count <= count - (RBUF_PTR_W+1)'(1);
            default: count <= count;
         endcase
      end
   end

   // Registered output strobe
   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= 1'b0;
      else
         out_valid <= deliver;
   end

   always_ff @(posedge clk)
   begin
      if (deliver)
         out_data <= mem[rd_ptr];
   end

endmodule

// File: hw/sram_fifo_top.sv
// SRAM load, clock enable and output enable are not driven here; tie them off at the board
`timescale 1ns/1ps

module sram_fifo_top
   import sram_fifo_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              push,
   input  logic [DATA_W-1:0] push_data,
   input  logic              out_hold,
   input  logic [DATA_W-1:0] ram_dq_rd,
   output logic              full,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data,
   output logic [ADDR_W-1:0] ram_a,
   output logic              ram_we_n,
   output logic              ram_ce1_n,
   output logic [DATA_W-1:0] ram_dq_wr,
   output logic              ram_dq_drive_n
);

   // Controller to SRAM interface
   logic              req_en;
   logic              req_write;
   logic [ADDR_W-1:0] req_addr;
   logic [DATA_W-1:0] req_data;

   // SRAM interface to return buffer
   logic [DATA_W-1:0] rd_data;
   logic              rd_valid;

   // Credit return
   logic              pop;

   sram_fifo_ctrl ctrl0 (
      .clk       (clk),
      .rst       (rst),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .full      (full),
      .req_en    (req_en),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_data  (req_data)
   );

   nobl_if nobl0 (
      .clk            (clk),
      .rst            (rst),
      .req_en         (req_en),
      .req_write      (req_write),
      .req_addr       (req_addr),
      .req_data       (req_data),
      .ram_dq_rd      (ram_dq_rd),
      .rd_data        (rd_data),
      .rd_valid       (rd_valid),
      .ram_a          (ram_a),
      .ram_we_n       (ram_we_n),
      .ram_ce1_n      (ram_ce1_n),
      .ram_dq_wr      (ram_dq_wr),
      .ram_dq_drive_n (ram_dq_drive_n)
   );

   sram_read_buf rbuf0 (
      .clk       (clk),
      .rst       (rst),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .out_hold  (out_hold),
      .out_valid (out_valid),
      .out_data  (out_data),
      .pop       (pop)
   );

endmodule

// File: test/nobl_sram_model.sv
// Pipelined NoBL SRAM model; load, clock enable and output enable held active, no byte lanes
`timescale 1ns/1ps

module nobl_sram_model
   import sram_fifo_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] ram_a,
   input  logic              ram_we_n,
   input  logic              ram_ce1_n,
   input  logic [DATA_W-1:0] ram_dq_wr,
   input  logic              ram_dq_drive_n,
   output logic [DATA_W-1:0] ram_dq_rd
);

   // Pins tied inside the model
   localparam logic ADV_LD_N = 1'b0;
   localparam logic CEN_N    = 1'b0;
   localparam logic OE_N     = 1'b0;

   logic [DATA_W-1:0] mem [FIFO_WORDS];
   logic              rd_s1;
   logic              wr_s1;
   logic [ADDR_W-1:0] addr_s1;
   logic              wr_s2;
   logic [ADDR_W-1:0] addr_s2;

   // Address and controls sampled one edge after they reach the pins
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rd_s1 <= 1'b0;
         wr_s1 <= 1'b0;
      end
      else
      begin
         rd_s1 <= ~ram_ce1_n & ~ADV_LD_N & ~CEN_N & ram_we_n;
         wr_s1 <= ~ram_ce1_n & ~ADV_LD_N & ~CEN_N & ~ram_we_n;
      end
      addr_s1 <= ram_a;
   end

   // Read data out one edge after sampling
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_s2     <= 1'b0;
         ram_dq_rd <= '0;
      end
      else
      begin
         wr_s2     <= wr_s1;
         ram_dq_rd <= (rd_s1 & ~OE_N) ? mem[addr_s1] : 'x;
      end
      addr_s2 <= addr_s1;
   end

   // Late write; an undriven bus stores X so the bad word shows at the output
   always_ff @(posedge clk)
   begin
      if (wr_s2)
         mem[addr_s2] <= ram_dq_drive_n ? 'x : ram_dq_wr;
   end

endmodule

// File: test/tb_sram_fifo.sv
// Random stimulus from a fixed LFSR seed; every word out is checked against a queue model
`timescale 1ns/1ps

module tb_sram_fifo
   import sram_fifo_pkg::*;
();

   logic              clk;
   logic              rst;
   logic              push;
   logic [DATA_W-1:0] push_data;
   logic              out_hold;
   logic              full;
   logic              out_valid;
   logic [DATA_W-1:0] out_data;
   logic [ADDR_W-1:0] ram_a;
   logic              ram_we_n;
   logic              ram_ce1_n;
   logic [DATA_W-1:0] ram_dq_wr;
   logic              ram_dq_drive_n;
   logic [DATA_W-1:0] ram_dq_rd;

   logic [DATA_W-1:0] exp_q [$];
   logic [15:0]       lfsr_state;
   logic              hold_applied;
   int                errors;
   int                checks;
   int                tests_run;
   int                tests_failed;
   int                err_base;

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   sram_fifo_top dut0 (.*);

   nobl_sram_model ram0 (.*);

   // Taps 16, 14, 13, 11
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsr_bit()};
      return v;
   endfunction

   function automatic logic [DATA_W-1:0] random_word();
      return DATA_W'(lfsr_bits(DATA_W));
   endfunction

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("Failure at %0t: %s", $time, msg);
   endtask

   // Sample outputs at the falling edge, where they are stable
   task automatic tick();
      @(negedge clk);
      if (out_valid)
      begin
         if (hold_applied)
            check_equal("out_valid", out_valid, 1'b0);
         if (exp_q.size() == 0)
            report_failure("a word came out while none was expected");
         else
            check_equal("out_data", out_data, exp_q.pop_front());
      end
      // Queue holds words in the SRAM plus reads not yet delivered
      if (full && exp_q.size() < FIFO_WORDS)
         report_failure($sformatf("full is high with only %0d words held", exp_q.size()));
      if (!full && exp_q.size() >= FIFO_WORDS + RBUF_DEPTH)
         report_failure($sformatf("full is low with %0d words held", exp_q.size()));
   endtask

   task automatic drive(input logic want, input logic [DATA_W-1:0] data, input logic hold);
      if (want && !full)
         exp_q.push_back(data);
      push         = want;
      push_data    = data;
      out_hold     = hold;
      hold_applied = hold;
   endtask

   task automatic drain(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < limit)
      begin
         tick();
         drive(1'b0, '0, 1'b0);
         n++;
      end
      if (exp_q.size() != 0)
         report_failure($sformatf("%0d words still missing after %0d cycles",
                                  exp_q.size(), limit));
      // Quiet cycles catch extra words
      repeat (10)
      begin
         tick();
         drive(1'b0, '0, 1'b0);
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != err_base)
         tests_failed++;
      $display("%s: %s", name, (errors == err_base) ? "ok" : "failed");
      err_base = errors;
   endtask

   initial
   begin
      int  n;
      logic hold;
      $timeformat(-9, 0, " ns", 0);
      lfsr_state   = 16'd43;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      err_base     = 0;
      rst          = 1'b1;
      push         = 1'b0;
      push_data    = '0;
      out_hold     = 1'b0;
      hold_applied = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      check_equal("ram_ce1_n", ram_ce1_n, 1'b1);
      check_equal("ram_we_n", ram_we_n, 1'b1);
      check_equal("ram_dq_drive_n", ram_dq_drive_n, 1'b1);
      check_equal("full", full, 1'b0);
      check_equal("out_valid", out_valid, 1'b0);
      repeat (50)
      begin
         tick();
         drive(1'b0, '0, 1'b0);
      end
      finish_test("reset and idle");

      repeat (20)
      begin
         tick();
         drive(1'b1, random_word(), 1'b1);
      end
      check_equal("words queued", exp_q.size(), 20);
      repeat (20)
      begin
         tick();
         drive(1'b0, '0, 1'b1);
      end
      drain(200);
      finish_test("fill and drain");

      // Random gaps let eight reads reach the return buffer before full
      n = 0;
      tick();
      while (!full && n < 4000)
      begin
         drive(lfsr_bit(), random_word(), 1'b1);
         tick();
         n++;
      end
      if (!full)
         report_failure("full never rose while the output was held");
      check_equal("words at full", exp_q.size(), FIFO_WORDS + RBUF_DEPTH);
      repeat (16)
      begin
         drive(1'b1, random_word(), 1'b1);
         tick();
      end
      check_equal("full", full, 1'b1);
      drive(1'b0, '0, 1'b0);
      drain(5000);
      finish_test("full flag");

      hold = 1'b0;
      repeat (1500)
      begin
         tick();
         if (lfsr_bits(2) == 0)
            hold = ~hold;
         drive(lfsr_bits(2) != 0, random_word(), hold);
      end
      drain(5000);
      finish_test("back-pressure");

      repeat (3000)
      begin
         tick();
         drive(!full && lfsr_bit(), random_word(), lfsr_bits(2) == 0);
      end
      finish_test("random traffic");

      drain(5000);
      check_equal("full", full, 1'b0);
      finish_test("drain after traffic");

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: sim.f
hw/sram_fifo_pkg.sv
hw/nobl_if.sv
hw/sram_fifo_ctrl.sv
hw/sram_read_buf.sv
hw/sram_fifo_top.sv
test/nobl_sram_model.sv
test/tb_sram_fifo.sv
